// ==== common/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // Data and address word
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] reg_idx_t;

    // Internal opcode, one value per supported instruction
    // INVALID covers anything not decoded and behaves as a no-op
    typedef enum logic [4:0] {
        INVALID = 5'd0,
        ADDU    = 5'd1,
        SUBU    = 5'd2,
        AND     = 5'd3,
        OR      = 5'd4,
        XOR     = 5'd5,
        SLT     = 5'd6,
        SLL     = 5'd7,
        SRL     = 5'd8,
        ADDIU   = 5'd9,
        ANDI    = 5'd10,
        ORI     = 5'd11,
        LUI     = 5'd12,
        LW      = 5'd13,
        SW      = 5'd14,
        BEQ     = 5'd15,
        BNE     = 5'd16,
        J       = 5'd17,
        JR      = 5'd18
    } instr_code_t;

    // Step sequence of one instruction
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC1 = 2'd1,
        EXEC2 = 2'd2
    } step_t;

    // Boot address of the core
    localparam word_t reset_vector_default = 32'hBFC0_0000;

endpackage

`default_nettype wire

// ==== compile.f ====
common/mips_pkg.sv
hw/step_sequencer.sv
hw/instr_decoder.sv
hw/alu.sv
hw/register_file.sv
hw/program_counter.sv
hw/bus_access_unit.sv
hw/mips_cpu_bus.sv
verif/avalon_memory_model.sv
verif/tb_mips_cpu_bus.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  mips_pkg::word_t       a,
    input  mips_pkg::word_t       b,
    input  mips_pkg::instr_code_t op,
    input  logic [4:0]            shift_amount,
    output mips_pkg::word_t       result,
    output logic                  zero
);

    import mips_pkg::*;

    always_comb begin
        case (op)
            // Loads and stores add base and offset
            ADDU, ADDIU, LW, SW: result = a + b;
            // Branches compare by subtracting rt from rs
            SUBU, BEQ, BNE:      result = a - b;
            AND, ANDI:           result = a & b;
            OR, ORI:             result = a | b;
            XOR:                 result = a ^ b;
            SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            SLL:                 result = b << shift_amount;
            SRL:                 result = b >> shift_amount;
            LUI:                 result = b << 16;
            default:             result = '0;
        endcase
    end

    // Used by BEQ and BNE
    always_comb begin
        zero = (result == '0);
    end

endmodule

`default_nettype wire

// ==== hw/bus_access_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_access_unit (
    input  logic                  fetch,
    input  logic                  exec1,
    input  logic                  waitrequest,
    input  logic                  clk,
    input  logic                  rst_n,
    input  mips_pkg::instr_code_t instr_code,
    input  mips_pkg::word_t       pc,
    input  mips_pkg::word_t       alu_result,
    input  mips_pkg::word_t       store_data,
    input  mips_pkg::word_t       readdata,
    input  logic                  pc_halt,
    output mips_pkg::word_t       address,
    output mips_pkg::word_t       writedata,
    output mips_pkg::word_t       load_data,
    output logic                  read,
    output logic                  write,
    output logic                  mem_stall,
    output logic                  bus_done,
    output logic [3:0]            byteenable
);

    import mips_pkg::*;

    logic data_phase;

    // Command and address follow the step, so they hold while the step is stalled
    always_comb begin
        data_phase = exec1 && !pc_halt;
        read       = 1'b0;
        write      = 1'b0;
        address    = pc;
        if (fetch && !pc_halt) begin
            read = 1'b1;
        end else if (data_phase && (instr_code == LW)) begin
            read    = 1'b1;
            address = alu_result;
        end else if (data_phase && (instr_code == SW)) begin
            write   = 1'b1;
            address = alu_result;
        end
        writedata  = store_data;
        byteenable = 4'b1111;
    end

    always_comb begin
        mem_stall = (read || write) && waitrequest;
        bus_done  = (read || write) && !waitrequest;
    end

    // Load word kept for write-back in exec2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_data <= '0;
        end else if (exec1 && read && !waitrequest) begin
            load_data <= readdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch,
    input  logic                     bus_done,
    input  mips_pkg::word_t          instr_word,
    output mips_pkg::reg_idx_t       rs_idx,
    output mips_pkg::reg_idx_t       rt_idx,
    output mips_pkg::reg_idx_t       dest_idx,
    output mips_pkg::word_t          immediate,
    output logic [4:0]               shift_amount,
    output logic [25:0]              jump_index,
    output mips_pkg::instr_code_t    instr_code,
    output logic                     reg_write_en
);

    import mips_pkg::*;

    word_t      ir;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       r_type;
    logic       zero_ext;

    // Instruction register, loaded when the fetch read completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (fetch && bus_done) begin
            ir <= instr_word;
        end
    end

    always_comb begin
        opcode       = ir[31:26];
        funct        = ir[5:0];
        rs_idx       = ir[25:21];
        rt_idx       = ir[20:16];
        shift_amount = ir[10:6];
        jump_index   = ir[25:0];
        r_type       = (opcode == 6'h00);
        dest_idx     = r_type ? ir[15:11] : ir[20:16];
    end

    // Opcode and funct to internal code
    always_comb begin
        instr_code = INVALID;
        if (r_type) begin
            case (funct)
                6'h21:   instr_code = ADDU;
                6'h23:   instr_code = SUBU;
                6'h24:   instr_code = AND;
                6'h25:   instr_code = OR;
                6'h26:   instr_code = XOR;
                6'h2A:   instr_code = SLT;
                6'h00:   instr_code = SLL;
                6'h02:   instr_code = SRL;
                6'h08:   instr_code = JR;
                default: instr_code = INVALID;
            endcase
        end else begin
            case (opcode)
                6'h09:   instr_code = ADDIU;
                6'h0C:   instr_code = ANDI;
                6'h0D:   instr_code = ORI;
                6'h0F:   instr_code = LUI;
                6'h23:   instr_code = LW;
                6'h2B:   instr_code = SW;
                6'h04:   instr_code = BEQ;
                6'h05:   instr_code = BNE;
                6'h02:   instr_code = J;
                default: instr_code = INVALID;
            endcase
        end
    end

    // Logic immediates and LUI take the zero-extended form
    always_comb begin
        zero_ext  = (instr_code == ANDI) || (instr_code == ORI) || (instr_code == LUI);
        immediate = zero_ext ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    end

    always_comb begin
        case (instr_code)
            ADDU, SUBU, AND, OR, XOR, SLT, SLL, SRL: reg_write_en = 1'b1;
            ADDIU, ANDI, ORI, LUI, LW:               reg_write_en = 1'b1;
            default:                                 reg_write_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/mips_cpu_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_bus #(
    parameter mips_pkg::word_t RESET_VECTOR = mips_pkg::reset_vector_default
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t register_v0,

    // Avalon master
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata
);

    import mips_pkg::*;

    logic        fetch, exec1, exec2;
    logic        stall, mem_stall, pc_halt, bus_done;
    logic        reg_write_en, reg_write, zero;
    logic [4:0]  shift_amount;
    logic [25:0] jump_index;
    reg_idx_t    rs_idx, rt_idx, dest_idx;
    word_t       rs_data, rt_data, immediate, alu_b, alu_result;
    word_t       pc, load_data, write_data;
    instr_code_t instr_code;

    always_comb begin
        active    = !pc_halt;
        stall     = mem_stall || pc_halt;
        reg_write = reg_write_en && exec2 && !stall;
    end

    // ALU operand b
    always_comb begin
        case (instr_code)
            ADDIU, ANDI, ORI, LUI, LW, SW: alu_b = immediate;
            default:                       alu_b = rt_data;
        endcase
    end

    // Write-back source
    always_comb begin
        write_data = (instr_code == LW) ? load_data : alu_result;
    end

    step_sequencer u_step_sequencer (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .fetch (fetch),
        .exec1 (exec1),
        .exec2 (exec2)
    );

    instr_decoder u_instr_decoder (
        .clk (clk), .rst_n (rst_n), .fetch (fetch), .bus_done (bus_done),
        .instr_word   (readdata),
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .dest_idx     (dest_idx),
        .immediate    (immediate),
        .shift_amount (shift_amount),
        .jump_index   (jump_index),
        .instr_code   (instr_code),
        .reg_write_en (reg_write_en)
    );

    alu u_alu (
        .a (rs_data), .b (alu_b), .op (instr_code), .shift_amount (shift_amount),
        .result (alu_result), .zero (zero)
    );

    register_file u_register_file (
        .clk (clk), .rst_n (rst_n), .write_en (reg_write),
        .rs_idx (rs_idx), .rt_idx (rt_idx), .write_idx (dest_idx),
        .write_data (write_data),
        .rs_data (rs_data), .rt_data (rt_data), .v0 (register_v0)
    );

    program_counter #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_program_counter (
        .clk (clk), .rst_n (rst_n), .exec2 (exec2), .stall (stall),
        .instr_code      (instr_code),
        .immediate       (immediate),
        .jump_target_reg (rs_data),
        .jump_index      (jump_index),
        .zero            (zero),
        .pc              (pc),
        .pc_halt         (pc_halt)
    );

    bus_access_unit u_bus_access_unit (
        .fetch (fetch), .exec1 (exec1), .waitrequest (waitrequest),
        .clk (clk), .rst_n (rst_n),
        .instr_code (instr_code), .pc (pc), .alu_result (alu_result),
        .store_data (rt_data), .readdata (readdata), .pc_halt (pc_halt),
        .address (address), .writedata (writedata), .load_data (load_data),
        .read (read), .write (write), .mem_stall (mem_stall), .bus_done (bus_done),
        .byteenable (byteenable)
    );

endmodule

`default_nettype wire

// ==== hw/program_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module program_counter #(
    parameter mips_pkg::word_t RESET_VECTOR = mips_pkg::reset_vector_default
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  exec2,
    input  logic                  stall,
    input  mips_pkg::instr_code_t instr_code,
    input  mips_pkg::word_t       immediate,
    input  mips_pkg::word_t       jump_target_reg,
    input  logic [25:0]           jump_index,
    input  logic                  zero,
    output mips_pkg::word_t       pc,
    output logic                  pc_halt
);

    import mips_pkg::*;

    word_t pc_plus4;
    word_t next_pc;

    always_comb begin
        pc_plus4 = pc + 32'd4;
        case (instr_code)
            BEQ:     next_pc = zero ? pc_plus4 + (immediate << 2) : pc_plus4;
            BNE:     next_pc = zero ? pc_plus4 : pc_plus4 + (immediate << 2);
            J:       next_pc = {pc[31:28], jump_index, 2'b00};
            JR:      next_pc = jump_target_reg;
            default: next_pc = pc_plus4;
        endcase
    end

    // PC moves once per instruction, at the end of exec2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= RESET_VECTOR;
            pc_halt <= 1'b0;
        end else if (exec2 && !stall) begin
            pc <= next_pc;
            if (next_pc == '0) begin
                pc_halt <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               write_en,
    input  mips_pkg::reg_idx_t rs_idx,
    input  mips_pkg::reg_idx_t rt_idx,
    input  mips_pkg::reg_idx_t write_idx,
    input  mips_pkg::word_t    write_data,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    v0
);

    import mips_pkg::*;

    word_t regs [32];

    // Entry 0 is cleared at reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_idx != 5'd0)) begin
            regs[write_idx] <= write_data;
        end
    end

    always_comb begin
        rs_data = regs[rs_idx];
        rt_data = regs[rt_idx];
        v0      = regs[2];
    end

endmodule

`default_nettype wire

// ==== hw/step_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module step_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,
    output logic fetch,
    output logic exec1,
    output logic exec2
);

    import mips_pkg::*;

    step_t state;

    // Advance one step per clock unless the bus or the PC holds us
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH;
        end else if (!stall) begin
            case (state)
                FETCH:   state <= EXEC1;
                EXEC1:   state <= EXEC2;
                EXEC2:   state <= FETCH;
                default: state <= FETCH;
            endcase
        end
    end

    // One-hot step strobes
    always_comb begin
        fetch = (state == FETCH);
        exec1 = (state == EXEC1);
        exec2 = (state == EXEC2);
    end

endmodule

`default_nettype wire

// ==== verif/avalon_memory_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module avalon_memory_model #(
    parameter int MEM_WORDS   = 256,
    parameter int SEED        = 1,
    parameter int DRIVE_DELAY = 5
) (
    input  logic            clk,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    output mips_pkg::word_t readdata,
    output logic            waitrequest
);

    import mips_pkg::*;

    localparam int IDX_BITS = $clog2(MEM_WORDS);

    word_t               mem [MEM_WORDS];
    logic [IDX_BITS-1:0] word_idx;
    int unsigned         seed_state;

    // Word addressed memory that ignores the low two address bits
    always_comb begin
        word_idx = address[IDX_BITS+1:2];
        readdata = read ? mem[word_idx] : '0;
    end

    // Write commits only in the cycle the slave accepts it
    always @(posedge clk) begin
        if (write && !waitrequest) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[word_idx][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
    end

    // About one cycle in four is stretched
    initial begin
        waitrequest = 1'b0;
        seed_state  = SEED;
        void'($urandom(seed_state));
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            waitrequest = (($urandom % 4) == 0);
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_mips_cpu_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mips_cpu_bus;

    import mips_pkg::*;

    localparam int    CLK_PERIOD   = 40;
    localparam int    DRIVE_DELAY  = 5;
    localparam int    RESET_CYCLES = 2;
    localparam int    IDLE_CYCLES  = 4;
    localparam int    NUM_TESTS    = 8;
    localparam int    MAX_WORDS    = 8;
    localparam int    MEM_WORDS    = 256;
    localparam int    RANDOM_SEED  = 72010;
    localparam word_t BOOT_ADDR    = 32'h0000_0100;
    // Three steps per instruction, four times over for waitrequest, plus reset and idle checks
    localparam int    TIMEOUT_CYCLES =
        NUM_TESTS * (MAX_WORDS * 3 * 4 + RESET_CYCLES + IDLE_CYCLES + 4);

    // MIPS I opcode and funct fields
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_LUI   = 6'h0F;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2A;

    // jr $zero ends every program
    localparam word_t HALT_JR  = 32'h0000_0008;
    localparam word_t NOP_WORD = 32'h0000_0000;

    logic       clk;
    logic       rst_n;
    logic       waitrequest;
    logic       active;
    logic       read;
    logic       write;
    logic [3:0] byteenable;
    word_t      readdata;
    word_t      register_v0;
    word_t      address;
    word_t      writedata;
    int         cycle_count;
    int         test_idx;

    // Test table with word 0 of each program in the top bits
    logic [MAX_WORDS*32-1:0] program_image [NUM_TESTS];
    word_t                   expect_v0 [NUM_TESTS];
    logic                    check_mem [NUM_TESTS];
    word_t                   mem_addr [NUM_TESTS];
    word_t                   mem_expect [NUM_TESTS];

    mips_cpu_bus #(
        .RESET_VECTOR (BOOT_ADDR)
    ) u_mips_cpu_bus (
        .clk (clk), .rst_n (rst_n), .active (active), .register_v0 (register_v0),
        .address (address), .write (write), .read (read), .waitrequest (waitrequest),
        .writedata (writedata), .byteenable (byteenable), .readdata (readdata)
    );

    avalon_memory_model #(
        .MEM_WORDS (MEM_WORDS), .SEED (RANDOM_SEED), .DRIVE_DELAY (DRIVE_DELAY)
    ) u_mem (
        .clk (clk), .address (address), .read (read), .write (write),
        .writedata (writedata), .byteenable (byteenable),
        .readdata (readdata), .waitrequest (waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run("run did not finish within the cycle limit");
    end

    function automatic word_t enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [4:0] rd,
                                    input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
                                    input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task compare_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s in test %0d: got 0x%08h, expected 0x%08h",
                                name, test_idx, actual, expected));
        end
    endtask

    task compare_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s in test %0d: got 0x%h, expected 0x%h",
                                name, test_idx, actual, expected));
        end
    endtask

    // $v0 is register 2 and $t0 to $t2 are registers 8 to 10
    task fill_table;
        for (int t = 0; t < NUM_TESTS; t++) begin
            check_mem[t]  = 1'b0;
            mem_addr[t]   = '0;
            mem_expect[t] = '0;
        end
        // ADDU, SUBU, XOR
        program_image[0] = {
            enc_i(OP_LUI, 0, 8, 16'h1234), enc_i(OP_ORI, 8, 8, 16'h5678),
            enc_i(OP_LUI, 0, 9, 16'h1111), enc_i(OP_ORI, 9, 9, 16'h1111),
            enc_r(FN_ADDU, 8, 9, 10, 0), enc_r(FN_SUBU, 8, 9, 2, 0),
            enc_r(FN_XOR, 2, 10, 2, 0), HALT_JR};
        expect_v0[0] = 32'h2266_22EE;
        // AND then ORI
        program_image[1] = {
            enc_i(OP_LUI, 0, 8, 16'hFF00), enc_i(OP_ORI, 8, 8, 16'h00FF),
            enc_i(OP_LUI, 0, 9, 16'h0F0F), enc_i(OP_ORI, 9, 9, 16'hF0F0),
            enc_r(FN_AND, 8, 9, 2, 0), enc_i(OP_ORI, 2, 2, 16'h1300), HALT_JR, NOP_WORD};
        expect_v0[1] = 32'h0F00_13F0;
        // Signed SLT both ways, OR
        program_image[2] = {
            enc_i(OP_ADDIU, 0, 8, 16'hFFFF), enc_i(OP_ADDIU, 0, 9, 16'h0005),
            enc_r(FN_SLT, 8, 9, 2, 0), enc_r(FN_SLT, 9, 8, 10, 0),
            enc_r(FN_SLL, 0, 2, 2, 4), enc_r(FN_OR, 2, 10, 2, 0), HALT_JR, NOP_WORD};
        expect_v0[2] = 32'h0000_0010;
        // Sign extension for ADDIU, zero extension for ANDI and ORI
        program_image[3] = {
            enc_i(OP_ADDIU, 0, 8, 16'hFFF0), enc_i(OP_ANDI, 8, 9, 16'hFFFF),
            enc_i(OP_ORI, 0, 10, 16'h8000), enc_r(FN_ADDU, 9, 10, 2, 0),
            enc_i(OP_ADDIU, 2, 2, 16'hFFFF), enc_r(FN_ADDU, 2, 8, 2, 0), HALT_JR, NOP_WORD};
        expect_v0[3] = 32'h0001_7FDF;
        // SRL is logical, SLL by fixed amounts
        program_image[4] = {
            enc_i(OP_LUI, 0, 8, 16'h8001), enc_i(OP_ORI, 8, 8, 16'h0003),
            enc_r(FN_SRL, 0, 8, 9, 4), enc_r(FN_SLL, 0, 9, 2, 3),
            enc_r(FN_SRL, 0, 8, 10, 31), enc_r(FN_ADDU, 2, 10, 2, 0), HALT_JR, NOP_WORD};
        expect_v0[4] = 32'h4000_8001;
        // SW then LW at base 0x210 with offset -8 so both use 0x208
        program_image[5] = {
            enc_i(OP_ADDIU, 0, 8, 16'h0210), enc_i(OP_LUI, 0, 9, 16'hCAFE),
            enc_i(OP_ORI, 9, 9, 16'hBABE), enc_i(OP_SW, 8, 9, 16'hFFF8),
            enc_i(OP_LW, 8, 2, 16'hFFF8), HALT_JR, NOP_WORD, NOP_WORD};
        expect_v0[5]  = 32'hCAFE_BABE;
        check_mem[5]  = 1'b1;
        mem_addr[5]   = 32'h0000_0208;
        mem_expect[5] = 32'hCAFE_BABE;
        // Taken BEQ skips, untaken BNE falls through
        program_image[6] = {
            enc_i(OP_ADDIU, 0, 8, 16'h0007), enc_i(OP_ADDIU, 0, 9, 16'h0007),
            enc_i(OP_ADDIU, 0, 2, 16'h0001), enc_i(OP_BEQ, 8, 9, 16'h0001),
            enc_i(OP_ADDIU, 0, 2, 16'h0099), enc_i(OP_BNE, 8, 9, 16'h0001),
            enc_i(OP_ADDIU, 2, 2, 16'h0010), HALT_JR};
        expect_v0[6] = 32'h0000_0011;
        // J to 0x10C, JR to 0x118
        program_image[7] = {
            enc_i(OP_ADDIU, 0, 2, 16'h0001), enc_j(OP_J, 26'h000_0043),
            enc_i(OP_ADDIU, 0, 2, 16'h0055), enc_i(OP_ADDIU, 0, 8, 16'h0118),
            enc_r(FN_JR, 8, 0, 0, 0), enc_i(OP_ADDIU, 0, 2, 16'h0077),
            enc_i(OP_ADDIU, 2, 2, 16'h0020), HALT_JR};
        expect_v0[7] = 32'h0000_0021;
    endtask

    // Background pattern from the byte address, then the program at the boot address
    task load_program(input int t);
        int    i;
        word_t byte_addr;
        for (i = 0; i < MEM_WORDS; i++) begin
            byte_addr = i * 4;
            u_mem.mem[i] <= byte_addr ^ 32'hA5A5_5A5A;
        end
        for (i = 0; i < MAX_WORDS; i++) begin
            u_mem.mem[(BOOT_ADDR >> 2) + i] <= program_image[t][(MAX_WORDS - 1 - i) * 32 +: 32];
        end
    endtask

    task wait_for_halt;
        while (active !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    // Halted core stays quiet on the bus and keeps $v0
    task check_idle(input word_t final_v0);
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            compare_bit("active", active, 1'b0);
            compare_bit("read", read, 1'b0);
            compare_bit("write", write, 1'b0);
            compare_word("register_v0", register_v0, final_v0);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        test_idx = 0;
        fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_idx = t;
            @(posedge clk);
            #DRIVE_DELAY;
            rst_n = 1'b0;
            load_program(t);
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rst_n = 1'b1;
            // First fetch after reset comes from the boot address
            @(negedge clk);
            compare_bit("active", active, 1'b1);
            compare_bit("read", read, 1'b1);
            compare_word("address", address, BOOT_ADDR);
            wait_for_halt();
            compare_word("register_v0", register_v0, expect_v0[t]);
            if (check_mem[t]) begin
                compare_word("memory word", u_mem.mem[mem_addr[t] >> 2], mem_expect[t]);
            end
            check_idle(expect_v0[t]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
